// ==== src/ahb_arb_defines.svh ====
`ifndef AHB_ARB_DEFINES_SVH
`define AHB_ARB_DEFINES_SVH

// masters sharing one slave
`define AHB_MASTER_NUM  4
// width of a master index
`define AHB_MASTER_BIT  2

// legal priority values are 0 .. AHB_PRIOR_LEVEL-1, higher wins
`define AHB_PRIOR_LEVEL 3
// width of one priority value
`define AHB_PRIOR_BIT   2

`endif

// ==== src/ahb_arb_pkg.sv ====
`include "ahb_arb_defines.svh"

package ahb_arb_pkg;

  // ============================================================
  // burst encodings, as on the hburst bus
  // ============================================================
  // undefined-length incr is not supported
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } burst_type;

  // burst monitor
  typedef enum logic {
    MON_IDLE,
    MON_BURST
  } monitor_state_t;

  // configuration port opcodes
  typedef enum logic {
    CFG_READ,
    CFG_WRITE
  } cfg_op_t;

  // beat index of the last beat in a burst
  function automatic logic [3:0] burst_limit(input burst_type b);
    logic [3:0] lim;
    case (b)
      INCR4, WRAP4:   lim = 4'd3;
      INCR8, WRAP8:   lim = 4'd7;
      INCR16, WRAP16: lim = 4'd15;
      default:        lim = 4'd0;
    endcase
    return lim;
  endfunction

endpackage

// ==== src/prior_select.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defines.svh"

module prior_select
(
  input  logic [`AHB_MASTER_NUM-1:0]                     hreq,
  input  logic [`AHB_MASTER_NUM-1:0][`AHB_PRIOR_BIT-1:0] hprior,
  output logic [`AHB_MASTER_NUM-1:0]                     raw_grant
);

  // requesters sorted by their programmed level
  logic [`AHB_PRIOR_LEVEL-1:0][`AHB_MASTER_NUM-1:0] level_req;
  // requesters at the highest occupied level
  logic [`AHB_MASTER_NUM-1:0]                       top_req;

  // ============================================================
  // group requests per priority level
  // ============================================================
  always_comb
  begin
    for (int l = 0; l < `AHB_PRIOR_LEVEL; l++)
    begin
      for (int i = 0; i < `AHB_MASTER_NUM; i++)
      begin
        level_req[l][i] = hreq[i] && (hprior[i] == l);
      end
    end
  end

  // keep only the highest non-empty level
  always_comb
  begin
    top_req = '0;
    for (int l = 0; l < `AHB_PRIOR_LEVEL; l++)
    begin
      if (|level_req[l])
      begin
        top_req = level_req[l];
      end
    end
  end

  // ============================================================
  // tie break on lowest index
  // ============================================================
  // scan downwards so the lowest set bit is written last
  always_comb
  begin
    raw_grant = '0;
    for (int i = `AHB_MASTER_NUM - 1; i >= 0; i--)
    begin
      if (top_req[i])
      begin
        raw_grant    = '0;
        raw_grant[i] = 1'b1;
      end
    end
  end

endmodule

// ==== src/burst_monitor.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defines.svh"

module burst_monitor
(
  input  logic                   hclk,
  input  logic                   hreset_n,
  input  logic                   hsel,
  input  logic                   hwait,
  input  ahb_arb_pkg::burst_type hburst,
  output logic                   burst_last
);

  ahb_arb_pkg::monitor_state_t state;
  ahb_arb_pkg::monitor_state_t state_next;
  ahb_arb_pkg::burst_type      burst_q;
  ahb_arb_pkg::burst_type      burst_cur;
  logic [3:0]                  count;
  logic [3:0]                  count_cur;
  logic [3:0]                  count_next;
  logic [3:0]                  count_limit;
  logic                        beat;

  // accepted beat
  assign beat = hsel & ~hwait;

  // in idle the first cycle of a tenure looks at hburst directly
  always_comb
  begin
    if (state == ahb_arb_pkg::MON_IDLE)
    begin
      burst_cur = hburst;
      count_cur = '0;
    end
    else
    begin
      burst_cur = burst_q;
      count_cur = count;
    end
  end

  assign count_limit = ahb_arb_pkg::burst_limit(burst_cur);
  assign burst_last  = beat && (count_cur == count_limit);

  // ============================================================
  // next state and beat count
  // ============================================================
  always_comb
  begin
    state_next = state;
    count_next = count_cur;
    if (burst_last)
    begin
      state_next = ahb_arb_pkg::MON_IDLE;
      count_next = '0;
    end
    else if (hsel)
    begin
      state_next = ahb_arb_pkg::MON_BURST;
      if (beat)
      begin
        count_next = count_cur + 4'd1;
      end
    end
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      state   <= ahb_arb_pkg::MON_IDLE;
      count   <= '0;
      burst_q <= ahb_arb_pkg::SINGLE;
    end
    else
    begin
      state <= state_next;
      count <= count_next;
      // burst length fixed for the whole tenure
      if (state == ahb_arb_pkg::MON_IDLE && hsel)
      begin
        burst_q <= hburst;
      end
    end
  end

  // counter stays inside the latched burst
  assert property (@(posedge hclk) disable iff (!hreset_n)
    state == ahb_arb_pkg::MON_BURST |-> count <= ahb_arb_pkg::burst_limit(burst_q));

endmodule

// ==== src/prior_cfg_regs.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defines.svh"

module prior_cfg_regs
(
  input  logic                                           hclk,
  input  logic                                           hreset_n,
  input  logic                                           cfg_req,
  input  ahb_arb_pkg::cfg_op_t                           cfg_op,
  input  logic [`AHB_MASTER_BIT-1:0]                     cfg_master,
  input  logic [`AHB_PRIOR_BIT-1:0]                      cfg_wdata,
  output logic [`AHB_PRIOR_BIT-1:0]                      cfg_rdata,
  output logic                                           cfg_ack,
  output logic [`AHB_MASTER_NUM-1:0][`AHB_PRIOR_BIT-1:0] hprior
);

  localparam int unsigned               PRIOR_MAX_INT = `AHB_PRIOR_LEVEL - 1;
  localparam logic [`AHB_PRIOR_BIT-1:0] prior_max     = PRIOR_MAX_INT[`AHB_PRIOR_BIT-1:0];

  logic [`AHB_MASTER_NUM-1:0][`AHB_PRIOR_BIT-1:0] prior_q;
  logic [`AHB_PRIOR_BIT-1:0]                      wdata_sat;
  logic                                           start;

  // new request seen while idle
  assign start = cfg_req & ~cfg_ack;

  // clamp to the top legal level
  assign wdata_sat = (cfg_wdata > prior_max) ? prior_max : cfg_wdata;

  // ============================================================
  // handshake
  // ============================================================
  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      cfg_ack <= 1'b0;
    end
    else if (start)
    begin
      cfg_ack <= 1'b1;
    end
    else if (cfg_ack && !cfg_req)
    begin
      cfg_ack <= 1'b0;
    end
  end

  // ============================================================
  // priority table
  // ============================================================
  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      prior_q <= '0;
    end
    else if (start && cfg_op == ahb_arb_pkg::CFG_WRITE)
    begin
      prior_q[cfg_master] <= wdata_sat;
    end
  end

  // read data held for as long as ack stays high
  always_ff @(posedge hclk)
  begin
    if (start && cfg_op == ahb_arb_pkg::CFG_READ)
    begin
      cfg_rdata <= prior_q[cfg_master];
    end
  end

  assign hprior = prior_q;

  // a new request only starts once ack has dropped
  assert property (@(posedge hclk) disable iff (!hreset_n)
    $rose(cfg_req) |-> !cfg_ack);

  // requester keeps req up until it is acknowledged
  assert property (@(posedge hclk) disable iff (!hreset_n)
    cfg_req && !cfg_ack |=> cfg_req);

endmodule

// ==== src/ahb_slave_arbiter.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defines.svh"

module ahb_slave_arbiter
(
  input  logic                                           hclk,
  input  logic                                           hreset_n,
  input  logic [`AHB_MASTER_NUM-1:0]                     hreq,
  input  ahb_arb_pkg::burst_type                         hburst,
  input  logic                                           hwait,
  input  logic [`AHB_MASTER_NUM-1:0][`AHB_PRIOR_BIT-1:0] hprior,
  output logic [`AHB_MASTER_NUM-1:0]                     hgrant,
  output logic                                           hsel
);

  logic [`AHB_MASTER_NUM-1:0] raw_grant;
  logic [`AHB_MASTER_NUM-1:0] grant;
  logic                       burst_last;
  logic                       grant_load;

  // ============================================================
  // winner selection
  // ============================================================
  prior_select prior_select_inst
  (
    .hreq      (hreq),
    .hprior    (hprior),
    .raw_grant (raw_grant)
  );

  // ============================================================
  // grant register
  // ============================================================
  // re-arbitrate when empty or on the last accepted beat
  assign grant_load = (grant == '0) || burst_last;

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      grant <= '0;
    end
    else if (grant_load)
    begin
      grant <= raw_grant;
    end
  end

  assign hgrant = grant;
  assign hsel   = |grant;

  // ============================================================
  // burst tracking
  // ============================================================
  burst_monitor burst_monitor_inst
  (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .hsel       (hsel),
    .hwait      (hwait),
    .hburst     (hburst),
    .burst_last (burst_last)
  );

  // single owner at most
  assert property (@(posedge hclk) disable iff (!hreset_n)
    $onehot0(grant));

  // back-pressure keeps the current owner
  assert property (@(posedge hclk) disable iff (!hreset_n)
    hsel && hwait |=> $stable(grant));

endmodule

// ==== src/ahb_arb_top.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defines.svh"

module ahb_arb_top
(
  input  logic                         hclk,
  input  logic                         hreset_n,
  // bus side
  input  logic [`AHB_MASTER_NUM-1:0]   hreq,
  input  ahb_arb_pkg::burst_type       hburst,
  input  logic                         hwait,
  output logic [`AHB_MASTER_NUM-1:0]   hgrant,
  output logic                         hsel,
  // configuration port
  input  logic                         cfg_req,
  input  ahb_arb_pkg::cfg_op_t         cfg_op,
  input  logic [`AHB_MASTER_BIT-1:0]   cfg_master,
  input  logic [`AHB_PRIOR_BIT-1:0]    cfg_wdata,
  output logic [`AHB_PRIOR_BIT-1:0]    cfg_rdata,
  output logic                         cfg_ack
);

  // programmed level per master
  logic [`AHB_MASTER_NUM-1:0][`AHB_PRIOR_BIT-1:0] hprior;

  // ============================================================
  // priority registers
  // ============================================================
  prior_cfg_regs prior_cfg_regs_inst
  (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .cfg_req    (cfg_req),
    .cfg_op     (cfg_op),
    .cfg_master (cfg_master),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .cfg_ack    (cfg_ack),
    .hprior     (hprior)
  );

  // ============================================================
  // arbiter
  // ============================================================
  ahb_slave_arbiter ahb_slave_arbiter_inst
  (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hreq     (hreq),
    .hburst   (hburst),
    .hwait    (hwait),
    .hprior   (hprior),
    .hgrant   (hgrant),
    .hsel     (hsel)
  );

endmodule

// ==== sim/ahb_arb_tb.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defines.svh"

module ahb_arb_tb;

  localparam int WAIT_LIMIT = 200;

  logic                              hclk;
  logic                              hreset_n;
  logic [`AHB_MASTER_NUM-1:0]        hreq;
  ahb_arb_pkg::burst_type            hburst;
  logic                              hwait;
  logic [`AHB_MASTER_NUM-1:0]        hgrant;
  logic                              hsel;
  logic                              cfg_req;
  ahb_arb_pkg::cfg_op_t              cfg_op;
  logic [`AHB_MASTER_BIT-1:0]        cfg_master;
  logic [`AHB_PRIOR_BIT-1:0]         cfg_wdata;
  logic [`AHB_PRIOR_BIT-1:0]         cfg_rdata;
  logic                              cfg_ack;

  // reference model of grant, tenure and priority table
  logic [`AHB_MASTER_NUM-1:0]                     m_grant;
  logic [`AHB_MASTER_NUM-1:0][`AHB_PRIOR_BIT-1:0] m_prior;
  int                                             m_beats;
  int                                             m_len;
  logic                                           m_first;

  logic [31:0] lfsr;
  int          err_count;
  int          err_mark;
  int          test_count;

  ahb_arb_top ahb_arb_top_inst
  (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .hreq       (hreq),
    .hburst     (hburst),
    .hwait      (hwait),
    .hgrant     (hgrant),
    .hsel       (hsel),
    .cfg_req    (cfg_req),
    .cfg_op     (cfg_op),
    .cfg_master (cfg_master),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .cfg_ack    (cfg_ack)
  );

  initial
  begin
    hclk = 1'b0;
    forever #50 hclk = ~hclk;
  end

  // ============================================================
  // random bits and reference rules
  // ============================================================
  function automatic logic take_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
    begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  // encoding 3'b001 is undefined-length incr, not used here
  function automatic ahb_arb_pkg::burst_type burst_pick(input logic [2:0] v);
    return (v == 3'b001) ? ahb_arb_pkg::SINGLE : ahb_arb_pkg::burst_type'(v);
  endfunction

  function automatic int burst_len(input ahb_arb_pkg::burst_type b);
    case (b)
      ahb_arb_pkg::INCR4, ahb_arb_pkg::WRAP4:   return 4;
      ahb_arb_pkg::INCR8, ahb_arb_pkg::WRAP8:   return 8;
      ahb_arb_pkg::INCR16, ahb_arb_pkg::WRAP16: return 16;
      default:                                  return 1;
    endcase
  endfunction

  function automatic logic [`AHB_PRIOR_BIT-1:0] sat_prior(input logic [`AHB_PRIOR_BIT-1:0] v);
    logic [`AHB_PRIOR_BIT-1:0] top;
    top = `AHB_PRIOR_BIT'(`AHB_PRIOR_LEVEL - 1);
    return (v > top) ? top : v;
  endfunction

  // strictly greater keeps the lowest index on a tie
  function automatic logic [`AHB_MASTER_NUM-1:0] predict_grant(
    input logic [`AHB_MASTER_NUM-1:0]                     req,
    input logic [`AHB_MASTER_NUM-1:0][`AHB_PRIOR_BIT-1:0] prior
  );
    logic [`AHB_MASTER_NUM-1:0] win;
    int                         best;
    win  = '0;
    best = -1;
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      if (req[i] && int'(prior[i]) > best)
      begin
        best   = int'(prior[i]);
        win    = '0;
        win[i] = 1'b1;
      end
    end
    return win;
  endfunction

  // ============================================================
  // reference model
  // ============================================================
  always @(posedge hclk or negedge hreset_n)
  begin : model
    int   len;
    logic last;
    if (!hreset_n)
    begin
      m_grant <= '0;
      m_prior <= '0;
      m_beats <= 0;
      m_len   <= 1;
      m_first <= 1'b1;
    end
    else
    begin
      len  = m_first ? burst_len(hburst) : m_len;
      last = (m_grant != '0) && !hwait && (m_beats == len - 1);
      if (m_grant != '0 && m_first)
      begin
        m_len <= len;
      end
      if (m_grant == '0 || last)
      begin
        m_grant <= predict_grant(hreq, m_prior);
        m_beats <= 0;
        m_first <= 1'b1;
      end
      else
      begin
        m_first <= 1'b0;
        if (!hwait)
        begin
          m_beats <= m_beats + 1;
        end
      end
      // a write lands on the edge that raises ack
      if (cfg_req && !cfg_ack && cfg_op == ahb_arb_pkg::CFG_WRITE)
      begin
        m_prior[cfg_master] <= sat_prior(cfg_wdata);
      end
    end
  end

  // ============================================================
  // checks
  // ============================================================
  grant_model: assert property (@(posedge hclk) disable iff (!hreset_n) hgrant == m_grant)
    else
    begin
      $display("mismatch at %0t: hgrant expected %b got %b",
               $time, $sampled(m_grant), $sampled(hgrant));
      err_count++;
    end

  hsel_or: assert property (@(posedge hclk) disable iff (!hreset_n) hsel == (m_grant != '0))
    else
    begin
      $display("mismatch at %0t: hsel expected %b got %b",
               $time, $sampled(m_grant != '0), $sampled(hsel));
      err_count++;
    end

  ack_rise: assert property (@(posedge hclk) disable iff (!hreset_n)
    $rose(cfg_ack) |-> $past(cfg_req))
    else
    begin
      $display("at %0t cfg_ack rose with no request pending", $time);
      err_count++;
    end

  ack_fall: assert property (@(posedge hclk) disable iff (!hreset_n)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else
    begin
      $display("at %0t cfg_ack fell while cfg_req was still high", $time);
      err_count++;
    end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got)
    else
    begin
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("at %0t gave up waiting for %s", $time, what);
    err_count++;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %0d %s finished with %0d failed checks",
             test_count, name, err_count - err_mark);
    err_mark = err_count;
  endtask

  // loops on falling edges until (hgrant == want) equals match
  task automatic wait_grant(input logic [`AHB_MASTER_NUM-1:0] want, input logic match);
    int t;
    t = 0;
    do
    begin
      @(negedge hclk);
      t++;
    end
    while (((hgrant == want) != match) && t < WAIT_LIMIT);
    if ((hgrant == want) != match)
    begin
      report_timeout($sformatf("hgrant %s %b", match ? "to equal" : "to leave", want));
    end
  endtask

  task automatic cfg_access(input ahb_arb_pkg::cfg_op_t op, input logic [1:0] master,
                            input logic [1:0] wdata, output logic [1:0] rdata);
    int t;
    @(posedge hclk);
    cfg_req    <= 1'b1;
    cfg_op     <= op;
    cfg_master <= master;
    cfg_wdata  <= wdata;
    t = 0;
    do
    begin
      @(negedge hclk);
      t++;
    end
    while (!cfg_ack && t < WAIT_LIMIT);
    if (!cfg_ack)
    begin
      report_timeout("cfg_ack to rise");
    end
    rdata = cfg_rdata;
    @(posedge hclk);
    cfg_req <= 1'b0;
    t = 0;
    do
    begin
      @(negedge hclk);
      t++;
    end
    while (cfg_ack && t < WAIT_LIMIT);
    if (cfg_ack)
    begin
      report_timeout("cfg_ack to fall");
    end
  endtask

  task automatic cfg_write(input logic [1:0] master, input logic [1:0] value);
    logic [1:0] unused;
    cfg_access(ahb_arb_pkg::CFG_WRITE, master, value, unused);
  endtask

  task automatic first_grant(input logic [3:0] req, input logic [3:0] exp);
    wait_grant(4'b0000, 1'b1);
    @(posedge hclk);
    hreq   <= req;
    hburst <= ahb_arb_pkg::SINGLE;
    wait_grant(4'b0000, 1'b0);
    check_val("hgrant", exp, hgrant);
    @(posedge hclk);
    hreq <= '0;
    wait_grant(4'b0000, 1'b1);
  endtask

  // master 0 owns a burst while higher levels request and hwait toggles
  task automatic burst_hold(input ahb_arb_pkg::burst_type b);
    int   beats;
    int   t;
    logic done;
    wait_grant(4'b0000, 1'b1);
    @(posedge hclk);
    hreq   <= 4'b0001;
    hburst <= b;
    hwait  <= 1'b0;
    // higher levels start requesting as master 0 is granted
    @(posedge hclk);
    hreq <= 4'b1110;
    wait_grant(4'b0001, 1'b1);
    beats = 1;
    done  = 1'b0;
    t     = 0;
    while (!done && t < WAIT_LIMIT)
    begin
      @(posedge hclk);
      hwait <= take_bit();
      @(negedge hclk);
      t++;
      if (hgrant != 4'b0001)
      begin
        done = 1'b1;
      end
      else if (!hwait)
      begin
        beats++;
      end
    end
    if (!done)
    begin
      report_timeout("end of burst");
    end
    check_val("accepted beats", burst_len(b), beats);
    check_val("hgrant after burst", 4'b0100, hgrant);
    @(posedge hclk);
    hreq  <= '0;
    hwait <= 1'b0;
    wait_grant(4'b0000, 1'b1);
  endtask

  // ============================================================
  // test sequence
  // ============================================================
  initial
  begin
    ahb_arb_pkg::burst_type b;
    logic [1:0]             rd;
    lfsr       = 32'h5987;
    err_count  = 0;
    err_mark   = 0;
    test_count = 0;
    hreset_n   = 1'b0;
    hreq       = '0;
    hburst     = ahb_arb_pkg::SINGLE;
    hwait      = 1'b0;
    cfg_req    = 1'b0;
    cfg_op     = ahb_arb_pkg::CFG_READ;
    cfg_master = '0;
    cfg_wdata  = '0;
    repeat (4) @(posedge hclk);
    hreset_n <= 1'b1;

    @(negedge hclk);
    check_val("hgrant", 0, hgrant);
    check_val("hsel", 0, hsel);
    check_val("cfg_ack", 0, cfg_ack);
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      @(posedge hclk);
      hreq <= 4'b0001 << i;
      @(negedge hclk);
      check_val("hgrant", 0, hgrant);
      @(posedge hclk);
      hreq <= '0;
      @(negedge hclk);
      check_val("hgrant", 4'b0001 << i, hgrant);
      check_val("hsel", 1, hsel);
      wait_grant(4'b0000, 1'b1);
    end
    end_test("reset and single grant");

    // value 3 saturates to the top level
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      cfg_write(2'(i), 2'(i + 1));
    end
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      cfg_access(ahb_arb_pkg::CFG_READ, 2'(i), 2'b00, rd);
      check_val("cfg_rdata", sat_prior(2'(i + 1)), rd);
    end
    end_test("configuration handshake");

    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      cfg_write(2'(i), 2'd0);
    end
    first_grant(4'b1110, 4'b0010);
    first_grant(4'b1001, 4'b0001);
    cfg_write(2'd0, 2'd1);
    cfg_write(2'd2, 2'd2);
    cfg_write(2'd3, 2'd2);
    first_grant(4'b1011, 4'b1000);
    first_grant(4'b0011, 4'b0001);
    first_grant(4'b1100, 4'b0100);
    end_test("priority selection");

    b = b.first();
    repeat (b.num())
    begin
      burst_hold(b);
      b = b.next();
    end
    end_test("burst hold");

    @(posedge hclk);
    hreq   <= 4'b1100;
    hburst <= ahb_arb_pkg::INCR4;
    wait_grant(4'b0100, 1'b1);
    @(posedge hclk);
    hreq <= 4'b1000;
    wait_grant(4'b0100, 1'b0);
    check_val("hgrant after burst", 4'b1000, hgrant);
    @(posedge hclk);
    hreq <= '0;
    wait_grant(4'b0000, 1'b1);
    end_test("back to back tenures");

    for (int c = 0; c < 400; c++)
    begin
      if (c % 50 == 49)
      begin
        cfg_write(2'(take_bits(2)), 2'(take_bits(2)));
      end
      @(posedge hclk);
      hreq   <= `AHB_MASTER_NUM'(take_bits(4));
      hburst <= burst_pick(3'(take_bits(3)));
      hwait  <= take_bit();
    end
    @(posedge hclk);
    hreq  <= '0;
    hwait <= 1'b0;
    wait_grant(4'b0000, 1'b1);
    end_test("random traffic");

    $display("tests run %0d, failed checks %0d", test_count, err_count);
    if (err_count == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/ahb_arb_pkg.sv
src/prior_select.sv
src/burst_monitor.sv
src/prior_cfg_regs.sv
src/ahb_slave_arbiter.sv
src/ahb_arb_top.sv
sim/ahb_arb_tb.sv

// ==== Bender.yml ====
package:
  name: ahb_arb

sources:
  - include_dirs:
      - src
    files:
      - src/ahb_arb_pkg.sv
      - src/prior_select.sv
      - src/burst_monitor.sv
      - src/prior_cfg_regs.sv
      - src/ahb_slave_arbiter.sv
      - src/ahb_arb_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/ahb_arb_tb.sv
